// File: video_pkg.sv
package video_pkg;

    localparam int COORD_W = 13;              // Every position field
    localparam int PCNT_W  = 6;               // Pixel divider field
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;

    // Register offsets on the write port
    localparam logic [ADDR_W-1:0] REG_CTRL    = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] REG_H1      = 32'h0000_0028;
    localparam logic [ADDR_W-1:0] REG_H2      = 32'h0000_0030;
    localparam logic [ADDR_W-1:0] REG_V1      = 32'h0000_0038;
    localparam logic [ADDR_W-1:0] REG_V2      = 32'h0000_0040;
    localparam logic [ADDR_W-1:0] REG_BASE    = 32'h0000_0048;
    localparam logic [ADDR_W-1:0] REG_LINEINC = 32'h0000_0050;

    localparam int CTRL_EN_BIT  = 3;          // CTRL[3]
    localparam int CTRL_PCNT_LO = 4;          // CTRL[9:4]

    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
    localparam int FREE_W      = $clog2(FIFO_DEPTH + 1);
    localparam int MEM_CREDITS = 4;
    localparam int CRED_W      = $clog2(MEM_CREDITS + 1);

    typedef struct packed {
        logic [7:0] r;                        // Word bits 23:16
        logic [7:0] g;                        // Word bits 15:8
        logic [7:0] b;                        // Word bits 7:0
    } rgb_t;

    typedef struct packed {
        logic              en;
        logic [PCNT_W-1:0] pcnt;              // Clocks per pixel minus one
    } ctrl_cfg_t;

    typedef struct packed {
        logic [COORD_W-1:0] size;             // Displayed pixels or lines
        logic [COORD_W-1:0] sync_start;
        logic [COORD_W-1:0] sync_end;         // First position after sync
        logic [COORD_W-1:0] total;
    } axis_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] base_address;
        logic [ADDR_W-1:0] lineinc;           // Bytes from one line to the next
    } fetch_cfg_t;

    typedef struct packed {
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
    } sync_t;

    // Output levels while reset or disabled
    localparam sync_t SYNC_IDLE = '{hsync: 1'b0, hblank: 1'b1, vsync: 1'b0, vblank: 1'b1};

endpackage

// File: video_regs.sv
module video_regs (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           reg_wr,
    input  logic [video_pkg::ADDR_W-1:0]   reg_addr,
    input  logic [video_pkg::DATA_W-1:0]   reg_wdata,
    output video_pkg::ctrl_cfg_t           ctrl_cfg,
    output video_pkg::axis_cfg_t           h_cfg,
    output video_pkg::axis_cfg_t           v_cfg,
    output video_pkg::fetch_cfg_t          fetch_cfg
);
    import video_pkg::*;

    logic [COORD_W-1:0] lo_field;
    logic [COORD_W-1:0] hi_field;

    // H1/V1 and H2/V2 share the same two 13-bit slots
    assign lo_field = reg_wdata[COORD_W-1:0];
    assign hi_field = reg_wdata[2*COORD_W-1:COORD_W];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_cfg  <= '0;
            h_cfg     <= '0;
            v_cfg     <= '0;
            fetch_cfg <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_CTRL: begin
                    ctrl_cfg.en   <= reg_wdata[CTRL_EN_BIT];
                    ctrl_cfg.pcnt <= reg_wdata[CTRL_PCNT_LO +: PCNT_W];
                end
                REG_H1: begin
                    h_cfg.total <= lo_field;
                    h_cfg.size  <= hi_field;
                end
                REG_H2: begin
                    h_cfg.sync_end   <= lo_field;
                    h_cfg.sync_start <= hi_field;
                end
                REG_V1: begin
                    v_cfg.total <= lo_field;
                    v_cfg.size  <= hi_field;
                end
                REG_V2: begin
                    v_cfg.sync_end   <= lo_field;
                    v_cfg.sync_start <= hi_field;
                end
                REG_BASE: begin
                    fetch_cfg.base_address <= reg_wdata;
                end
                REG_LINEINC: begin
                    fetch_cfg.lineinc <= reg_wdata;
                end
                default: begin
                end                                 // Unknown offsets dropped
            endcase
        end
    end

endmodule

// File: video_timing.sv
module video_timing (
    input  logic                           clk,
    input  logic                           reset_n,
    input  video_pkg::ctrl_cfg_t           ctrl_cfg,
    input  video_pkg::axis_cfg_t           h_cfg,
    input  video_pkg::axis_cfg_t           v_cfg,
    output logic                           pix_tick,
    output logic                           active,
    output logic                           fetch_line,
    output logic [video_pkg::COORD_W-1:0]  fetch_y,
    output video_pkg::sync_t               sync
);
    import video_pkg::*;

    logic [PCNT_W-1:0]  pdiv;                 // Clock within the pixel slot
    logic [COORD_W-1:0] hcnt;
    logic [COORD_W-1:0] vcnt;
    logic               h_last;
    logic               v_last;

    // >= keeps the counters bounded if totals shrink mid-frame
    assign pix_tick = ctrl_cfg.en && (pdiv >= ctrl_cfg.pcnt);
    assign h_last   = (hcnt >= h_cfg.total - 1'b1);
    assign v_last   = (vcnt >= v_cfg.total - 1'b1);

    assign active = ctrl_cfg.en && (hcnt < h_cfg.size) && (vcnt < v_cfg.size);

    // Next line number, also the vertical counter's next value
    assign fetch_y = v_last ? '0 : vcnt + 1'b1;

    // First blank slot of a line triggers the prefetch of the next one
    assign fetch_line = pix_tick && (hcnt == h_cfg.size) && (fetch_y < v_cfg.size);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pdiv <= '0;
        end else if (!ctrl_cfg.en || pix_tick) begin
            pdiv <= '0;
        end else begin
            pdiv <= pdiv + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (!ctrl_cfg.en) begin
            hcnt <= '0;                       // Held at origin while disabled
            vcnt <= '0;
        end else if (pix_tick) begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= fetch_y;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // One clock behind the counters, sampled every clock
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync <= SYNC_IDLE;
        end else if (!ctrl_cfg.en) begin
            sync <= SYNC_IDLE;
        end else begin
            sync.hblank <= (hcnt >= h_cfg.size);
            sync.hsync  <= (hcnt >= h_cfg.sync_start) && (hcnt < h_cfg.sync_end);
            sync.vblank <= (vcnt >= v_cfg.size);
            sync.vsync  <= (vcnt >= v_cfg.sync_start) && (vcnt < v_cfg.sync_end);
        end
    end

endmodule

// File: line_fetch.sv
module line_fetch (
    input  logic                           clk,
    input  logic                           reset_n,
    input  video_pkg::fetch_cfg_t          fetch_cfg,
    input  video_pkg::axis_cfg_t           h_cfg,
    input  logic                           fetch_line,
    input  logic [video_pkg::COORD_W-1:0]  fetch_y,
    output logic                           mem_req,
    output logic [video_pkg::ADDR_W-1:0]   mem_addr,
    input  logic                           mem_credit,
    input  logic                           mem_rsp_valid,
    input  logic [video_pkg::DATA_W-1:0]   mem_rsp_data,
    output logic                           fifo_wr,
    output video_pkg::rgb_t                fifo_wdata,
    input  logic                           fifo_pop
);
    import video_pkg::*;

    logic [COORD_W-1:0] remaining;            // Pixels still to request
    logic [ADDR_W-1:0]  next_addr;
    logic [CRED_W-1:0]  credits;
    logic [FREE_W-1:0]  free_slots;           // FIFO entries not yet claimed
    logic               issue;

    // A request needs a memory credit and a reserved FIFO slot
    assign issue = !fetch_line && (remaining != '0) && (credits != '0) &&
                   (free_slots != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_req    <= 1'b0;
            remaining  <= '0;
            credits    <= CRED_W'(MEM_CREDITS);
            free_slots <= FREE_W'(FIFO_DEPTH);
        end else begin
            mem_req    <= issue;
            credits    <= credits - CRED_W'(issue) + CRED_W'(mem_credit);
            free_slots <= free_slots - FREE_W'(issue) + FREE_W'(fifo_pop);
            if (fetch_line) begin
                remaining <= h_cfg.size;
            end else if (issue) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // Line start address, then 4 bytes per pixel
    always_ff @(posedge clk) begin
        if (fetch_line) begin
            next_addr <= fetch_cfg.base_address + ADDR_W'(fetch_y) * fetch_cfg.lineinc;
        end else if (issue) begin
            next_addr <= next_addr + ADDR_W'(4);
        end
        if (issue) begin
            mem_addr <= next_addr;
        end
    end

    // Space was reserved at request time so every response is written
    assign fifo_wr    = mem_rsp_valid;
    assign fifo_wdata = '{r: mem_rsp_data[23:16],
                          g: mem_rsp_data[15:8],
                          b: mem_rsp_data[7:0]};

endmodule

// File: pixel_fifo.sv
module pixel_fifo (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            wr,
    input  video_pkg::rgb_t wdata,
    input  logic            pop,
    output video_pkg::rgb_t rdata,
    output logic            empty
);
    import video_pkg::*;

    rgb_t             mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;                 // MSB is the wrap bit
    logic [FIFO_AW:0] rd_ptr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr[FIFO_AW-1:0]];  // Head, no read latency
    assign empty = (wr_ptr == rd_ptr);

endmodule

// File: pixel_output.sv
module pixel_output (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            pix_tick,
    input  logic            active,
    input  logic            fifo_empty,
    input  video_pkg::rgb_t fifo_rdata,
    output logic            pop,
    output video_pkg::rgb_t rgb
);

    // Head is the current slot's pixel, popped on the slot's last clock
    assign pop = pix_tick && active && !fifo_empty;

    // Loaded every clock like the sync outputs so both stay aligned
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rgb <= '0;
        end else if (active && !fifo_empty) begin
            rgb <= fifo_rdata;
        end else begin
            rgb <= '0;                        // Blanking or underrun
        end
    end

endmodule

// File: video_ctrl_top.sv
module video_ctrl_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           reg_wr,
    input  logic [video_pkg::ADDR_W-1:0]   reg_addr,
    input  logic [video_pkg::DATA_W-1:0]   reg_wdata,
    output logic                           mem_req,
    output logic [video_pkg::ADDR_W-1:0]   mem_addr,
    input  logic                           mem_credit,
    input  logic                           mem_rsp_valid,
    input  logic [video_pkg::DATA_W-1:0]   mem_rsp_data,
    output video_pkg::sync_t               sync,
    output video_pkg::rgb_t                rgb
);
    import video_pkg::*;

    ctrl_cfg_t          ctrl_cfg;
    axis_cfg_t          h_cfg;
    axis_cfg_t          v_cfg;
    fetch_cfg_t         fetch_cfg;
    logic               pix_tick;
    logic               active;
    logic               fetch_line;
    logic [COORD_W-1:0] fetch_y;
    logic               fifo_wr;
    rgb_t               fifo_wdata;
    logic               fifo_pop;             // Also frees a reserved slot
    rgb_t               fifo_rdata;
    logic               fifo_empty;

    video_regs i_video_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .ctrl_cfg  (ctrl_cfg),
        .h_cfg     (h_cfg),
        .v_cfg     (v_cfg),
        .fetch_cfg (fetch_cfg)
    );

    video_timing i_video_timing (
        .clk        (clk),
        .reset_n    (reset_n),
        .ctrl_cfg   (ctrl_cfg),
        .h_cfg      (h_cfg),
        .v_cfg      (v_cfg),
        .pix_tick   (pix_tick),
        .active     (active),
        .fetch_line (fetch_line),
        .fetch_y    (fetch_y),
        .sync       (sync)
    );

    line_fetch i_line_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .fetch_cfg     (fetch_cfg),
        .h_cfg         (h_cfg),
        .fetch_line    (fetch_line),
        .fetch_y       (fetch_y),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .fifo_wr       (fifo_wr),
        .fifo_wdata    (fifo_wdata),
        .fifo_pop      (fifo_pop)
    );

    pixel_fifo i_pixel_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .wr      (fifo_wr),
        .wdata   (fifo_wdata),
        .pop     (fifo_pop),
        .rdata   (fifo_rdata),
        .empty   (fifo_empty)
    );

    pixel_output i_pixel_output (
        .clk        (clk),
        .reset_n    (reset_n),
        .pix_tick   (pix_tick),
        .active     (active),
        .fifo_empty (fifo_empty),
        .fifo_rdata (fifo_rdata),
        .pop        (fifo_pop),
        .rgb        (rgb)
    );

endmodule

// File: tb_video_mem.sv
module tb_video_mem (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] seed,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_credit,
    output logic        mem_rsp_valid,
    output logic [31:0] mem_rsp_data
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [15:0] lfsr;
    logic [1:0]  latency;
    logic [31:0] word;
    int          cycle;
    int          due;
    int          last_due;
    int          due_q [$];                   // Response cycle of each open request
    logic [31:0] word_q [$];

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr     = 16'd47693;
            cycle    = 0;
            last_due = 0;
            due_q.delete();
            word_q.delete();
            mem_credit    <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
        end else begin
            cycle = cycle + 1;
            if (mem_req) begin
                lfsr       = lfsr_next(lfsr);
                latency[0] = lfsr[0];
                lfsr       = lfsr_next(lfsr);
                latency[1] = lfsr[0];
                due        = cycle + int'(latency) + 1;   // 1 to 4 cycles
                if (due <= last_due) begin
                    due = last_due + 1;       // Responses stay in request order
                end
                last_due = due;
                due_q.push_back(due);
                word_q.push_back(mem_addr + seed);
            end
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                word = word_q.pop_front();
                due_q.delete(0);
                mem_rsp_valid <= 1'b1;
                mem_credit    <= 1'b1;        // Credit returns with the data
                mem_rsp_data  <= word;
            end else begin
                mem_rsp_valid <= 1'b0;
                mem_credit    <= 1'b0;
                mem_rsp_data  <= '0;
            end
        end
    end

endmodule

// File: tb_video_ctrl.sv
module tb_video_ctrl;
    timeunit 1ns;
    timeprecision 1ns;
    import video_pkg::*;

    logic              clk;
    logic              reset_n;
    logic              reg_wr;
    logic [ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_credit;
    logic              mem_rsp_valid;
    logic [DATA_W-1:0] mem_rsp_data;
    sync_t             sync;
    rgb_t              rgb;

    logic [31:0] mem_seed;
    logic [31:0] exp_val [8];                 // Indexed as in video_tests.txt
    logic [31:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    logic [31:0] base;
    logic [31:0] lineinc;
    logic [31:0] addr;
    sync_t       prev_sync = 4'b0101;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 100000;
    int          cyc = 0;
    int          hs_rise_t = 0;
    int          hb_fall_t = 0;
    int          hb_cnt = 0;
    int          hs_in_vs = 0;
    int          lines_in_frame = 0;
    int          vs_rises = 0;
    int          line_idx = 0;
    int          cur_y = 0;
    int          pix_count = 0;
    int          in_flight = 0;
    int          x;
    bit          hs_seen = 1'b0;
    bit          en_written = 1'b0;

    video_ctrl_top i_video_ctrl_top (.*);
    tb_video_mem i_tb_video_mem (.seed(mem_seed), .*);

    always #10 clk = ~clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic load_tests(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        ok = 1'b0;
        fd = $fopen("video_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %h %h", kind, a, b);
                if (n == 3 && kind == "w") begin
                    wr_addr_q.push_back(a);
                    wr_data_q.push_back(b);
                end else if (n >= 2 && kind == "m") begin
                    mem_seed = a;
                end else if (n == 3 && kind == "e") begin
                    exp_val[a[2:0]] = b;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_reg(input logic [31:0] offset, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= offset;
        reg_wdata <= data;
        if (offset == REG_BASE) begin
            base = data;
        end
        if (offset == REG_LINEINC) begin
            lineinc = data;
        end
        if (offset == REG_CTRL && data[3]) begin
            en_written = 1'b1;                // Idle checks stop here
        end
    endtask

    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!en_written) begin
            check(32'(sync), 32'h5, "sync idle before enable");
            check(32'(mem_req), 32'h0, "no mem_req before enable");
        end
        // Requests not yet answered by a credit stay within the grant
        if (mem_req) begin
            in_flight++;
            check(32'(in_flight <= MEM_CREDITS), 32'h1, "mem_req within credits");
        end
        if (mem_credit) begin
            in_flight--;
        end
        if (sync.hblank || sync.vblank) begin
            check(32'(rgb), 32'h0, "rgb zero in blanking");
        end
        if (sync.vblank) begin
            line_idx = 0;
        end
        if (sync.hsync && !prev_sync.hsync) begin
            if (hs_seen) begin
                check(cyc - hs_rise_t, exp_val[0], "hsync period");
            end
            hs_seen   = 1'b1;
            hs_rise_t = cyc;
            lines_in_frame++;
            if (sync.vsync) begin
                hs_in_vs++;
            end
        end
        if (!sync.hsync && prev_sync.hsync) begin
            check(cyc - hs_rise_t, exp_val[1], "hsync width");
        end
        if (sync.vsync && !prev_sync.vsync) begin
            if (vs_rises > 0) begin
                check(lines_in_frame, exp_val[3], "lines per frame");
            end
            vs_rises++;
            lines_in_frame = 0;
            hs_in_vs       = 0;
        end
        if (!sync.vsync && prev_sync.vsync) begin
            check(hs_in_vs, exp_val[2], "vsync width in lines");
        end
        if (!sync.hblank && prev_sync.hblank) begin
            hb_fall_t = cyc;
            hb_cnt    = 0;
            if (!sync.vblank) begin
                cur_y = line_idx;
                line_idx++;
            end
        end else if (!sync.hblank) begin
            hb_cnt++;
        end
        if (sync.hblank && !prev_sync.hblank) begin
            check(cyc - hb_fall_t, exp_val[4], "hblank low width");
        end
        // First clock of each pixel slot, second frame onward
        if (!sync.hblank && !sync.vblank && vs_rises > 0 &&
            hb_cnt % int'(exp_val[5]) == 0) begin
            x    = hb_cnt / int'(exp_val[5]);
            addr = base + lineinc * cur_y + 4 * x;
            check(32'(rgb), (addr + mem_seed) & 32'h00ff_ffff, "pixel data");
            pix_count++;
        end
        prev_sync = sync;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: third frame not reached within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        bit ok;
        clk       = 1'b0;
        reset_n   = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        mem_seed  = '0;
        load_tests(ok);
        if (!ok) begin
            $display("could not open video_tests.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            limit = 3 * int'(exp_val[0]) * int'(exp_val[3]) + 400;   // Three frames
            repeat (8) @(posedge clk);
            reset_n <= 1'b1;
            foreach (wr_addr_q[i]) begin
                write_reg(wr_addr_q[i], wr_data_q[i]);
            end
            @(posedge clk);
            reg_wr <= 1'b0;
            wait (vs_rises >= 3);
            check(pix_count, 2 * exp_val[6] * exp_val[7], "pixels sampled in two frames");
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// File: video_tests.txt
# kind a b, all hex. w = register write (a offset, b value), m = memory seed in a
# e = expected figure (a index, b value)
w 00000028 00018014
w 00000030 0001c011
w 00000038 0000c00a
w 00000040 0000e009
w 00000048 00100000
w 00000050 00000100
w 00000008 ffffffff
w 00000000 00000038
m 3c5a7e00 0
# e index: 0 line clocks, 1 hsync clocks, 2 vsync lines, 3 lines per frame
# 4 hblank low clocks, 5 clocks per pixel, 6 active lines, 7 active pixels
e 0 50
e 1 c
e 2 2
e 3 a
e 4 30
e 5 4
e 6 6
e 7 c

// File: project.f
video_pkg.sv
video_regs.sv
video_timing.sv
line_fetch.sv
pixel_fifo.sv
pixel_output.sv
video_ctrl_top.sv
tb_video_mem.sv
tb_video_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_video_ctrl -f project.f || exit 1
out=$(./obj_dir/Vtb_video_ctrl)
echo "$out"
echo "$out" | grep -qF "Simulation finished: PASS" && exit 0 || exit 1
